// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
design/cache_pkg.sv
design/cache_ctrl_if.sv
design/meta_array.sv
design/line_array.sv
design/cache_datapath.sv
design/cache_control.sv
design/cache.sv
tests/clock_gen.sv
tests/pmem_model.sv
tests/cache_tb.sv

// ==== design/cache.sv ====
// Cache top level joining the FSM and the datapath, with plain processor and memory ports
`timescale 1ns/100ps

module cache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::word_t      mem_address,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  cache_pkg::byte_mask_t mem_byte_enable256,
    input  cache_pkg::line_t      mem_wdata256,
    output cache_pkg::line_t      mem_rdata256,
    output logic                  mem_resp,
    output cache_pkg::word_t      pmem_address,
    output logic                  pmem_read,
    output logic                  pmem_write,
    input  cache_pkg::line_t      pmem_rdata,
    output cache_pkg::line_t      pmem_wdata,
    input  logic                  pmem_resp
);

    cache_ctrl_if ctl_bus ();

    cache_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctl        (ctl_bus.ctrl),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .pmem_resp  (pmem_resp)
    );

    cache_datapath u_datapath (
        .clk                (clk),
        .rst_n              (rst_n),
        .ctl                (ctl_bus.dp),
        .mem_address        (mem_address),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_wdata256       (mem_wdata256),
        .mem_rdata256       (mem_rdata256),
        .pmem_rdata         (pmem_rdata),
        .pmem_wdata         (pmem_wdata),
        .pmem_address       (pmem_address)
    );

endmodule

// ==== design/cache_control.sv ====
// Cache FSM sequencing compare, write-back and fill for one processor request at a time
`timescale 1ns/100ps

module cache_control (
    input  logic        clk,
    input  logic        rst_n,
    cache_ctrl_if.ctrl  ctl,
    input  logic        mem_read,
    input  logic        mem_write,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    input  logic        pmem_resp
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state    = state;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        ctl.store_hit = 1'b0;
        ctl.fill_line = 1'b0;
        ctl.touch_lru = 1'b0;
        ctl.wb_sel    = 1'b0;
        unique case (state)
            IDLE:
            begin
                if (mem_read || mem_write)
                    next_state = COMPARE;
            end
            COMPARE:
            begin
                if (ctl.hit)
                begin
                    mem_resp      = 1'b1;
                    ctl.touch_lru = 1'b1;
                    ctl.store_hit = mem_write;
                    next_state    = IDLE;
                end
                else if (ctl.victim_dirty)
                    next_state = WRITEBACK;
                else
                    next_state = FILL;
            end
            WRITEBACK:
            begin
                pmem_write = 1'b1;
                ctl.wb_sel = 1'b1;
                if (pmem_resp)
                    next_state = FILL;
            end
            FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctl.fill_line = 1'b1;
                    next_state    = COMPARE;    // Request hits on the retry
                end
            end
            default: next_state = IDLE;
        endcase
    end

    pmem_one_dir: assert property (
        @(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write)
    ) else $error("pmem_read and pmem_write high together");

    store_fill_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(ctl.store_hit && ctl.fill_line)
    ) else $error("store_hit and fill_line high together");

endmodule

// ==== design/cache_ctrl_if.sv ====
// Command and status bundle between the cache FSM and the cache datapath
`timescale 1ns/100ps

interface cache_ctrl_if;

    logic store_hit;    // Masked write into hit way
    logic fill_line;    // Load victim way from memory
    logic touch_lru;
    logic wb_sel;       // Victim address onto memory bus
    logic hit;
    logic victim_dirty;

    modport ctrl (
        output store_hit,
        output fill_line,
        output touch_lru,
        output wb_sel,
        input  hit,
        input  victim_dirty
    );

    modport dp (
        input  store_hit,
        input  fill_line,
        input  touch_lru,
        input  wb_sel,
        output hit,
        output victim_dirty
    );

endinterface

// ==== design/cache_datapath.sv ====
// Two-way cache datapath: tag compare, way enables, LRU, write merge and memory address select
`timescale 1ns/100ps

module cache_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    cache_ctrl_if.dp              ctl,
    input  cache_pkg::word_t      mem_address,
    input  cache_pkg::byte_mask_t mem_byte_enable256,
    input  cache_pkg::line_t      mem_wdata256,
    output cache_pkg::line_t      mem_rdata256,
    input  cache_pkg::line_t      pmem_rdata,
    output cache_pkg::line_t      pmem_wdata,
    output cache_pkg::word_t      pmem_address
);

    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t req_index;
    cache_pkg::line_t  line_din;
    cache_pkg::line_t  way_line [2];
    cache_pkg::tag_t   way_tag [2];
    cache_pkg::tag_t   victim_tag;
    logic [1:0]        way_valid;
    logic [1:0]        way_dirty;
    logic [1:0]        way_hit;
    logic [1:0]        victim_sel;
    logic              lru;

    assign req_tag   = mem_address[cache_pkg::S_OFFSET + cache_pkg::S_INDEX +: cache_pkg::S_TAG];
    assign req_index = mem_address[cache_pkg::S_OFFSET +: cache_pkg::S_INDEX];

    assign victim_sel = {lru, ~lru};    // LRU bit names the victim way
    assign line_din   = ctl.store_hit ? mem_wdata256 : pmem_rdata;

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        logic                  sel_store;
        logic                  sel_fill;
        cache_pkg::byte_mask_t line_we;

        assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
        assign sel_store  = ctl.store_hit && way_hit[w];
        assign sel_fill   = ctl.fill_line && victim_sel[w];
        assign line_we    = sel_fill  ? '1 :
                            sel_store ? mem_byte_enable256 : '0;

        line_array u_line (
            .clk      (clk),
            .rst_n    (rst_n),
            .write_en (line_we),
            .index    (req_index),
            .din      (line_din),
            .dout     (way_line[w])
        );

        meta_array #(.WIDTH(cache_pkg::S_TAG)) u_tag (
            .clk   (clk),
            .rst_n (rst_n),
            .load  (sel_fill),
            .index (req_index),
            .din   (req_tag),
            .dout  (way_tag[w])
        );

        meta_array #(.WIDTH(1)) u_valid (
            .clk   (clk),
            .rst_n (rst_n),
            .load  (sel_fill),
            .index (req_index),
            .din   (1'b1),
            .dout  (way_valid[w])
        );

        // Set on store, cleared on fill
        meta_array #(.WIDTH(1)) u_dirty (
            .clk   (clk),
            .rst_n (rst_n),
            .load  (sel_store || sel_fill),
            .index (req_index),
            .din   (ctl.store_hit),
            .dout  (way_dirty[w])
        );
    end

    meta_array #(.WIDTH(1)) u_lru (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ctl.touch_lru),
        .index (req_index),
        .din   (way_hit[0]),            // Way not hit becomes victim
        .dout  (lru)
    );

    assign ctl.hit          = |way_hit;
    assign ctl.victim_dirty = lru ? way_dirty[1] : way_dirty[0];

    assign mem_rdata256 = way_hit[1] ? way_line[1] : way_line[0];
    assign pmem_wdata   = lru ? way_line[1] : way_line[0];
    assign victim_tag   = lru ? way_tag[1] : way_tag[0];

    assign pmem_address = ctl.wb_sel ?
        {victim_tag, req_index, {cache_pkg::S_OFFSET{1'b0}}} :
        {mem_address[31:cache_pkg::S_OFFSET], {cache_pkg::S_OFFSET{1'b0}}};

    store_needs_hit: assert property (
        @(posedge clk) disable iff (!rst_n) ctl.store_hit |-> ctl.hit
    ) else $error("store_hit asserted without a tag hit");

endmodule

// ==== design/cache_pkg.sv ====
// Shared cache geometry and vector types, referenced by scoped name from the cache RTL
package cache_pkg;

    localparam int S_OFFSET   = 5;
    localparam int S_INDEX    = 3;
    localparam int S_TAG      = 24;
    localparam int NUM_SETS   = 8;
    localparam int LINE_BYTES = 32;

    typedef logic [31:0]             word_t;      // Address or data word
    typedef logic [8*LINE_BYTES-1:0] line_t;      // One 256-bit line
    typedef logic [S_TAG-1:0]        tag_t;
    typedef logic [S_INDEX-1:0]      index_t;
    typedef logic [LINE_BYTES-1:0]   byte_mask_t; // One bit per line byte

endpackage

// ==== design/line_array.sv ====
// Per-set line storage with byte write enables, used for both masked stores and fills
`timescale 1ns/100ps

module line_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::byte_mask_t write_en,
    input  cache_pkg::index_t     index,
    input  cache_pkg::line_t      din,
    output cache_pkg::line_t      dout
);

    cache_pkg::line_t lines [cache_pkg::NUM_SETS];

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < cache_pkg::LINE_BYTES; i++)
        begin
            if (rst_n && write_en[i])   // No writes land while reset held
                lines[index][8*i +: 8] <= din[8*i +: 8];
        end
    end

    assign dout = lines[index];

endmodule

// ==== design/meta_array.sv ====
// Per-set metadata store for tag, valid, dirty and LRU bits, read combinationally
`timescale 1ns/100ps

module meta_array #(
    parameter int WIDTH = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  cache_pkg::index_t     index,
    input  logic [WIDTH-1:0]      din,
    output logic [WIDTH-1:0]      dout
);

    logic [WIDTH-1:0] entries [cache_pkg::NUM_SETS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cache_pkg::NUM_SETS; i++)
                entries[i] <= '0;
        end
        else if (load)
            entries[index] <= din;
    end

    assign dout = entries[index];

endmodule

// ==== tests/cache_tb.sv ====
// Cache testbench driving directed and random requests against a shadow memory, checked by assertions
`timescale 1ns/100ps

module cache_tb;

    localparam int ANY          = 0;    // Hit or miss both allowed
    localparam int HIT          = 1;
    localparam int MISS         = 2;
    localparam int DIRECTED_OPS = 14;
    localparam int RAND_OPS     = 200;
    localparam int NUM_OPS      = DIRECTED_OPS + RAND_OPS;
    localparam int CYCLE_LIMIT  = 40 * NUM_OPS;

    logic                  clk;
    logic                  rst_n;
    cache_pkg::word_t      mem_address;
    logic                  mem_read;
    logic                  mem_write;
    cache_pkg::byte_mask_t mem_byte_enable256;
    cache_pkg::line_t      mem_wdata256;
    cache_pkg::line_t      mem_rdata256;
    logic                  mem_resp;
    cache_pkg::word_t      pmem_address;
    logic                  pmem_read;
    logic                  pmem_write;
    cache_pkg::line_t      pmem_rdata;
    cache_pkg::line_t      pmem_wdata;
    logic                  pmem_resp;

    cache_pkg::line_t      exp_rdata;
    logic                  expect_hit;
    logic                  expect_miss;
    cache_pkg::line_t      shadow [cache_pkg::word_t];
    logic [31:0]           lfsr = 32'd91;
    int                    cycle_count = 0;

    clock_gen u_clock (.clk(clk), .rst_n(rst_n));

    cache UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_address        (mem_address),
        .mem_read           (mem_read),
        .mem_write          (mem_write),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_wdata256       (mem_wdata256),
        .mem_rdata256       (mem_rdata256),
        .mem_resp           (mem_resp),
        .pmem_address       (pmem_address),
        .pmem_read          (pmem_read),
        .pmem_write         (pmem_write),
        .pmem_rdata         (pmem_rdata),
        .pmem_wdata         (pmem_wdata),
        .pmem_resp          (pmem_resp)
    );

    pmem_model u_pmem (
        .clk          (clk),
        .rst_n        (rst_n),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    function automatic cache_pkg::word_t make_addr(input logic [23:0] tag,
                                                   input logic [2:0] set,
                                                   input logic [4:0] offset);
        return {tag, set, offset};
    endfunction

    function automatic cache_pkg::line_t home_line(input cache_pkg::word_t line_addr);
        cache_pkg::line_t l;
        for (int w = 0; w < 8; w++)
            l[32*w +: 32] = line_addr + 32'(4 * w);
        return l;
    endfunction

    function automatic cache_pkg::line_t merge_bytes(input cache_pkg::line_t old_line,
                                                     input cache_pkg::line_t new_line,
                                                     input cache_pkg::byte_mask_t mask);
        cache_pkg::line_t l;
        for (int i = 0; i < 32; i++)
            l[8*i +: 8] = mask[i] ? new_line[8*i +: 8] : old_line[8*i +: 8];
        return l;
    endfunction

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = next_lfsr(lfsr);     // One step per bit
        end
    endtask

    // One request, held until mem_resp, then dropped
    task automatic access(input logic is_write, input cache_pkg::word_t addr,
                          input cache_pkg::byte_mask_t mask, input cache_pkg::line_t wdata,
                          input int outcome);
        cache_pkg::word_t line_addr;
        cache_pkg::line_t old_line;
        line_addr = {addr[31:5], 5'd0};
        old_line  = shadow.exists(line_addr) ? shadow[line_addr] : home_line(line_addr);
        @(posedge clk);
        mem_address        <= addr;
        mem_read           <= !is_write;
        mem_write          <= is_write;
        mem_byte_enable256 <= mask;
        mem_wdata256       <= wdata;
        exp_rdata          <= old_line;
        expect_hit         <= (outcome == HIT);
        expect_miss        <= (outcome == MISS);
        if (is_write)
            shadow[line_addr] = merge_bytes(old_line, wdata, mask);
        do
            @(posedge clk);
        while (!mem_resp);
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        expect_hit  <= 1'b0;
        expect_miss <= 1'b0;
    endtask

    task automatic run_random_mix();
        logic [31:0]      r;
        logic             is_wr;
        logic [1:0]       tag_bits;
        logic [1:0]       set_bits;
        logic [4:0]       offset;
        cache_pkg::line_t wdata;
        logic [31:0]      mask;
        for (int n = 0; n < RAND_OPS; n++)
        begin
            draw_bits(1, r);
            is_wr = r[0];
            draw_bits(2, r);
            tag_bits = r[1:0];
            draw_bits(2, r);
            set_bits = r[1:0];
            draw_bits(5, r);
            offset = r[4:0];
            mask  = '0;
            wdata = '0;
            if (is_wr)
            begin
                draw_bits(32, mask);
                for (int w = 0; w < 8; w++)
                begin
                    draw_bits(32, r);
                    wdata[32*w +: 32] = r;
                end
            end
            access(is_wr, make_addr({22'd0, tag_bits}, {1'b0, set_bits}, offset),
                   mask, wdata, ANY);
        end
    endtask

    read_data_ok: assert property (
        @(posedge clk) disable iff (!rst_n) (mem_resp && mem_read) |-> mem_rdata256 == exp_rdata
    ) else begin
        $display("Error: mem_rdata256 = 0x%h, expected 0x%h",
                 $sampled(mem_rdata256), $sampled(exp_rdata));
        $display("=== FAIL ===");
        $fatal(1);
    end

    hit_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (expect_hit && $rose(mem_read || mem_write)) |=> mem_resp
    ) else begin
        $display("Error: mem_resp = 0x%h one cycle after a hit request, expected 0x1",
                 $sampled(mem_resp));
        $display("=== FAIL ===");
        $fatal(1);
    end

    miss_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (expect_miss && $rose(mem_read || mem_write)) |=> !mem_resp
    ) else begin
        $display("Error: mem_resp = 0x%h one cycle after a miss request, expected 0x0",
                 $sampled(mem_resp));
        $display("=== FAIL ===");
        $fatal(1);
    end

    pmem_one_dir: assert property (
        @(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write)
    ) else begin
        $display("Error: pmem_read = 0x%h and pmem_write = 0x%h, expected at most one high",
                 $sampled(pmem_read), $sampled(pmem_write));
        $display("=== FAIL ===");
        $fatal(1);
    end

    pmem_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pmem_read || pmem_write) |-> pmem_address[4:0] == 5'd0
    ) else begin
        $display("Error: pmem_address = 0x%h, expected low five bits 0x00",
                 $sampled(pmem_address));
        $display("=== FAIL ===");
        $fatal(1);
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the requests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    initial
    begin
        mem_address        = '0;
        mem_read           = 1'b0;
        mem_write          = 1'b0;
        mem_byte_enable256 = '0;
        mem_wdata256       = '0;
        exp_rdata          = '0;
        expect_hit         = 1'b0;
        expect_miss        = 1'b0;
        wait (rst_n == 1'b1);
        // Read miss, then hits on the same line
        access(1'b0, make_addr(24'd1, 3'd0, 5'd4), '0, '0, MISS);
        access(1'b0, make_addr(24'd1, 3'd0, 5'd28), '0, '0, HIT);
        access(1'b1, make_addr(24'd1, 3'd0, 5'd0), 32'h8000_0101,
               {8{32'hA5C3_0F96}}, HIT);
        access(1'b0, make_addr(24'd1, 3'd0, 5'd8), '0, '0, HIT);
        // Two dirty lines in set 1, then a third tag forces write-backs
        access(1'b1, make_addr(24'd1, 3'd1, 5'd0), 32'h0F0F_0F0F,
               {8{32'h1234_5678}}, MISS);
        access(1'b1, make_addr(24'd2, 3'd1, 5'd0), '1, {8{32'h2222_2222}}, MISS);
        access(1'b0, make_addr(24'd3, 3'd1, 5'd0), '0, '0, MISS);
        access(1'b0, make_addr(24'd1, 3'd1, 5'd0), '0, '0, MISS);
        // A, B, A in set 2, then C replaces B
        access(1'b0, make_addr(24'd1, 3'd2, 5'd0), '0, '0, MISS);
        access(1'b0, make_addr(24'd2, 3'd2, 5'd0), '0, '0, MISS);
        access(1'b0, make_addr(24'd1, 3'd2, 5'd0), '0, '0, HIT);
        access(1'b0, make_addr(24'd3, 3'd2, 5'd0), '0, '0, MISS);
        access(1'b0, make_addr(24'd1, 3'd2, 5'd0), '0, '0, HIT);
        access(1'b0, make_addr(24'd2, 3'd2, 5'd0), '0, '0, MISS);
        run_random_mix();
        @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tests/clock_gen.sv ====
// Testbench clock and reset source, 20 ns clock with active-low reset held for four cycles
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;          // Released on a rising edge
    end

endmodule

// ==== tests/pmem_model.sv ====
// Line-wide physical memory model for the cache testbench, answers each transfer after 3 cycles
`timescale 1ns/100ps

module pmem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  cache_pkg::word_t pmem_address,
    input  logic             pmem_read,
    input  logic             pmem_write,
    input  cache_pkg::line_t pmem_wdata,
    output cache_pkg::line_t pmem_rdata,
    output logic             pmem_resp
);

    localparam int RESP_DELAY = 3;

    cache_pkg::line_t lines [cache_pkg::word_t];    // Written lines only
    cache_pkg::line_t rdata_q = '0;
    logic             resp_q  = 1'b0;
    int               wait_cnt = 0;

    // Unwritten lines hold the byte address of each word
    function automatic cache_pkg::line_t home_line(input cache_pkg::word_t line_addr);
        cache_pkg::line_t l;
        for (int w = 0; w < 8; w++)
            l[32*w +: 32] = line_addr + 32'(4 * w);
        return l;
    endfunction

    always @(posedge clk)
    begin
        resp_q <= 1'b0;
        if (!rst_n || resp_q || !(pmem_read || pmem_write))
            wait_cnt <= 0;
        else if (wait_cnt == RESP_DELAY - 1)
        begin
            resp_q   <= 1'b1;
            wait_cnt <= 0;
            if (pmem_write)
                lines[pmem_address] = pmem_wdata;
            else
                rdata_q <= lines.exists(pmem_address) ? lines[pmem_address] :
                                                        home_line(pmem_address);
        end
        else
            wait_cnt <= wait_cnt + 1;
    end

    assign pmem_rdata = rdata_q;
    assign pmem_resp  = resp_q;

endmodule
